// ==== rtl/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// datapath word width
`define DATA_W 32

// register stages in the multiplier pipeline
`define MUL_STAGES 3

// one shift-subtract step per quotient bit
`define DIV_ITERS `DATA_W

`endif

// ==== rtl/alu_op_pkg.sv ====
package alu_op_pkg;

    // flat opcode as delivered by decode
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_NOR, OP_XOR,
        OP_LUI,
        OP_SLL, OP_SRL, OP_SRA,
        OP_CLO, OP_CLZ,
        OP_MOVN, OP_MOVZ,
        OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU,   // immediate forms share these
        OP_MULT, OP_MULTU,
        OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
        OP_DIV, OP_DIVU,
        OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO
    } alu_op_e;

    typedef enum logic [2:0] {
        TRAP_NONE,
        TRAP_EQ,
        TRAP_NE,
        TRAP_GE,
        TRAP_GEU,
        TRAP_LT,
        TRAP_LTU
    } trap_cond_e;

    // which engine a muldiv request is for
    typedef enum logic {
        MD_MUL,
        MD_DIV
    } muldiv_kind_e;

endpackage

// ==== rtl/alu_data_pkg.sv ====
`include "alu_macros.svh"

package alu_data_pkg;

    typedef logic [`DATA_W-1:0] word_t;

    typedef logic [2*`DATA_W-1:0] dword_t;    // product, or {hi, lo}

    typedef logic [$clog2(`DATA_W)-1:0] shamt_t;

    // 0 to DATA_W inclusive, hence one extra bit
    typedef logic [$clog2(`DATA_W):0] bitcnt_t;

endpackage

// ==== rtl/muldiv_if.sv ====
`timescale 1ns/1ps

interface muldiv_if;

    logic                      start;       // one-cycle request pulse
    alu_op_pkg::muldiv_kind_e  kind;
    logic                      is_signed;
    alu_data_pkg::word_t       a;
    alu_data_pkg::word_t       b;

    logic                      mul_done;
    alu_data_pkg::dword_t      prod;

    logic                      div_done;
    alu_data_pkg::word_t       quot;
    alu_data_pkg::word_t       rem;

    modport ctrl (output start, kind, is_signed, a, b,
                  input  mul_done, prod, div_done, quot, rem);

    modport mul (input start, kind, a, b, output mul_done, prod);

    modport div (input start, kind, is_signed, a, b, output div_done, quot, rem);

endinterface

// ==== rtl/bit_count_lead.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module bit_count_lead (
    input  alu_data_pkg::word_t   value,
    input  logic                  count_ones,   // 1 for clo, 0 for clz
    output alu_data_pkg::bitcnt_t count
);

    // walk up from bit 0, so the highest mismatching bit wins
    always_comb begin
        count = alu_data_pkg::bitcnt_t'(`DATA_W);   // whole word matches
        for (int i = 0; i < `DATA_W; i++) begin
            if (value[i] != count_ones) begin
                count = alu_data_pkg::bitcnt_t'(`DATA_W - 1 - i);
            end
        end
    end

endmodule

// ==== rtl/trap_cond.sv ====
`timescale 1ns/1ps

module trap_cond (
    input  alu_op_pkg::trap_cond_e cond,
    input  alu_data_pkg::word_t    a,
    input  alu_data_pkg::word_t    b,
    output logic                   trap
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (cond)
            alu_op_pkg::TRAP_EQ:  trap = eq;
            alu_op_pkg::TRAP_NE:  trap = !eq;
            alu_op_pkg::TRAP_GE:  trap = !lt_s;
            alu_op_pkg::TRAP_GEU: trap = !lt_u;
            alu_op_pkg::TRAP_LT:  trap = lt_s;
            alu_op_pkg::TRAP_LTU: trap = lt_u;
            default:              trap = 1'b0;   // not a trap op
        endcase
    end

    // non-trap opcodes from the top must never raise an exception
    trap_none_quiet: assert final (!(cond == alu_op_pkg::TRAP_NONE && trap))
        else $error("trap raised with no trap condition selected");

endmodule

// ==== rtl/pipe_multiplier.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module pipe_multiplier (
    input logic    clk,
    input logic    reset,
    muldiv_if.mul  md
);

    localparam int ROWS   = 4;
    localparam int ROW_W  = `DATA_W / ROWS;     // multiplier bits per row
    localparam int RPROD_W = `DATA_W + ROW_W;
    localparam int PAIR_W = `DATA_W + 2 * ROW_W;

    logic                   take;
    logic [RPROD_W-1:0]     row_q [ROWS];
    logic [PAIR_W-1:0]      pair_q [2];
    alu_data_pkg::dword_t   prod_q;
    logic [`MUL_STAGES-1:0] vld;

    assign take = md.start && (md.kind == alu_op_pkg::MD_MUL);

    // valid travels with the three data stages below
    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[`MUL_STAGES-2:0], take};
        end
    end

    // stage 1: a times each byte-wide slice of b
    always_ff @(posedge clk) begin
        if (take) begin
            for (int r = 0; r < ROWS; r++) begin
                row_q[r] <= md.a * md.b[r*ROW_W +: ROW_W];
            end
        end
    end

    // stage 2: combine rows in pairs
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            pair_q[p] <= PAIR_W'(row_q[2*p]) + (PAIR_W'(row_q[2*p+1]) << ROW_W);
        end
    end

    // stage 3: final sum
    always_ff @(posedge clk) begin
        prod_q <= alu_data_pkg::dword_t'(pair_q[0])
                + (alu_data_pkg::dword_t'(pair_q[1]) << (2 * ROW_W));
    end

    assign md.prod     = prod_q;
    assign md.mul_done = vld[`MUL_STAGES-1];

endmodule

// ==== rtl/iter_divider.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module iter_divider (
    input logic    clk,
    input logic    reset,
    muldiv_if.div  md
);

    localparam int CNT_W = $clog2(`DIV_ITERS);

    logic                take;
    logic                running;
    logic [CNT_W-1:0]    iter;
    logic                last_iter;
    logic                q_neg;
    logic                r_neg;
    alu_data_pkg::word_t divisor;
    alu_data_pkg::word_t quot_acc;    // dividend shifts out as quotient shifts in
    alu_data_pkg::word_t rem_acc;
    logic [`DATA_W:0]    shifted;
    logic [`DATA_W:0]    diff;

    assign take      = md.start && (md.kind == alu_op_pkg::MD_DIV);
    assign last_iter = (iter == CNT_W'(`DIV_ITERS - 1));

    assign shifted = {rem_acc, quot_acc[`DATA_W-1]};
    assign diff    = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            running     <= 1'b0;
            iter        <= '0;
            md.div_done <= 1'b0;
        end else begin
            md.div_done <= running && last_iter;
            if (take) begin
                running <= 1'b1;
                iter    <= '0;
            end else if (running) begin
                iter <= iter + 1'b1;
                if (last_iter) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            q_neg    <= md.is_signed && (md.a[`DATA_W-1] ^ md.b[`DATA_W-1]);
            r_neg    <= md.is_signed && md.a[`DATA_W-1];   // remainder follows dividend
            quot_acc <= (md.is_signed && md.a[`DATA_W-1]) ? -md.a : md.a;
            divisor  <= (md.is_signed && md.b[`DATA_W-1]) ? -md.b : md.b;
            rem_acc  <= '0;
        end else if (running) begin
            if (!diff[`DATA_W]) begin          // trial subtract fits
                rem_acc  <= diff[`DATA_W-1:0];
                quot_acc <= {quot_acc[`DATA_W-2:0], 1'b1};
            end else begin
                rem_acc  <= shifted[`DATA_W-1:0];
                quot_acc <= {quot_acc[`DATA_W-2:0], 1'b0};
            end
        end
    end

    // zero divisor ends with all-ones magnitude and the dividend as remainder
    assign md.quot = q_neg ? -quot_acc : quot_acc;
    assign md.rem  = r_neg ? -rem_acc : rem_acc;

    no_restart: assert property (@(posedge clk) disable iff (reset) take |-> !running)
        else $error("divide request while a divide is running");

endmodule

// ==== rtl/hilo_unit.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module hilo_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  alu_op_pkg::alu_op_e   op,
    input  alu_data_pkg::word_t   src1,
    input  alu_data_pkg::word_t   src2,
    input  logic                  flush,
    output alu_data_pkg::word_t   hi,
    output alu_data_pkg::word_t   lo,
    output logic                  busy,
    output logic                  md_done,
    muldiv_if.ctrl                md
);

    typedef enum logic [1:0] {IDLE, WAIT_MUL, WAIT_DIV} state_e;

    state_e               state;
    logic                 is_mul;
    logic                 is_div;
    logic                 mul_signed;
    logic                 accept;
    logic                 prod_neg;
    alu_data_pkg::dword_t prod_fix;
    alu_data_pkg::dword_t md_result;

    assign is_mul = op inside {alu_op_pkg::OP_MULT, alu_op_pkg::OP_MULTU,
                               alu_op_pkg::OP_MADD, alu_op_pkg::OP_MADDU,
                               alu_op_pkg::OP_MSUB, alu_op_pkg::OP_MSUBU};
    assign is_div = op inside {alu_op_pkg::OP_DIV, alu_op_pkg::OP_DIVU};
    assign mul_signed = op inside {alu_op_pkg::OP_MULT, alu_op_pkg::OP_MADD,
                                   alu_op_pkg::OP_MSUB};

    assign accept  = (state == IDLE) && (is_mul || is_div) && !flush;
    assign busy    = (state != IDLE);
    assign md_done = ((state == WAIT_MUL) && md.mul_done)
                   || ((state == WAIT_DIV) && md.div_done);

    // operands are held by the caller, so signs are still valid at done
    assign prod_neg = mul_signed && (src1[`DATA_W-1] ^ src2[`DATA_W-1]);
    assign prod_fix = prod_neg ? -md.prod : md.prod;

    always_comb begin
        if (state == WAIT_DIV) begin
            md_result = {md.rem, md.quot};   // hi gets remainder
        end else if (op inside {alu_op_pkg::OP_MADD, alu_op_pkg::OP_MADDU}) begin
            md_result = {hi, lo} + prod_fix;
        end else if (op inside {alu_op_pkg::OP_MSUB, alu_op_pkg::OP_MSUBU}) begin
            md_result = {hi, lo} - prod_fix;
        end else begin
            md_result = prod_fix;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            md.start <= 1'b0;
        end else begin
            md.start <= accept;
            case (state)
                IDLE:     if (accept) state <= is_mul ? WAIT_MUL : WAIT_DIV;
                WAIT_MUL: if (md.mul_done) state <= IDLE;
                WAIT_DIV: if (md.div_done) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // request payload, multiplier sees magnitudes only
    always_ff @(posedge clk) begin
        if (accept) begin
            md.kind      <= is_mul ? alu_op_pkg::MD_MUL : alu_op_pkg::MD_DIV;
            md.is_signed <= mul_signed || (op == alu_op_pkg::OP_DIV);
            md.a         <= (mul_signed && src1[`DATA_W-1]) ? -src1 : src1;
            md.b         <= (mul_signed && src2[`DATA_W-1]) ? -src2 : src2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (md_done && !flush) begin
            {hi, lo} <= md_result;
        end else if ((state == IDLE) && !flush && (op == alu_op_pkg::OP_MTHI)) begin
            hi <= src1;
        end else if ((state == IDLE) && !flush && (op == alu_op_pkg::OP_MTLO)) begin
            lo <= src1;
        end
    end

    no_idle_done: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE) |-> !(md.mul_done || md.div_done))
        else $error("engine done seen with no request outstanding");

    // start only in the cycle right after leaving IDLE
    single_start: assert property (@(posedge clk) disable iff (reset)
        md.start |-> ($past(state) == IDLE))
        else $error("start issued while already busy");

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu (
    input  logic                clk,
    input  logic                reset,
    input  alu_op_pkg::alu_op_e op,
    input  alu_data_pkg::word_t src1,
    input  alu_data_pkg::word_t src2,
    input  logic                flush,
    output alu_data_pkg::word_t result,
    output logic                overflow,
    output logic                trap,
    output logic                busy,
    output logic                md_done
);

    localparam int MSB  = `DATA_W - 1;
    localparam int HALF = `DATA_W / 2;

    logic                   sub_mode;
    logic                   carry;
    logic                   slt_bit;
    logic                   sltu_bit;
    logic                   src1_zero;
    alu_data_pkg::word_t    adder_b;
    alu_data_pkg::word_t    sum;
    alu_data_pkg::word_t    hi;
    alu_data_pkg::word_t    lo;
    alu_data_pkg::shamt_t   sa;
    alu_data_pkg::bitcnt_t  lead_cnt;
    alu_op_pkg::trap_cond_e tcond;

    muldiv_if md_bus ();

    // one adder, b inverted plus carry-in for subtract and compares
    assign sub_mode = op inside {alu_op_pkg::OP_SUB, alu_op_pkg::OP_SUBU,
                                 alu_op_pkg::OP_SLT, alu_op_pkg::OP_SLTU};
    assign adder_b  = sub_mode ? ~src2 : src2;
    assign {carry, sum} = {1'b0, src1} + {1'b0, adder_b} + {{`DATA_W{1'b0}}, sub_mode};

    // like signs in, other sign out
    assign overflow = (op == alu_op_pkg::OP_ADD || op == alu_op_pkg::OP_SUB)
                    && (src1[MSB] == adder_b[MSB]) && (sum[MSB] != src1[MSB]);

    assign slt_bit  = (src1[MSB] & ~src2[MSB]) | (~(src1[MSB] ^ src2[MSB]) & sum[MSB]);
    assign sltu_bit = ~carry;   // borrow out

    assign sa        = src1[$bits(alu_data_pkg::shamt_t)-1:0];
    assign src1_zero = (src1 == '0);

    always_comb begin
        case (op)
            alu_op_pkg::OP_ADD,
            alu_op_pkg::OP_ADDU,
            alu_op_pkg::OP_SUB,
            alu_op_pkg::OP_SUBU: result = sum;
            alu_op_pkg::OP_SLT:  result = alu_data_pkg::word_t'(slt_bit);
            alu_op_pkg::OP_SLTU: result = alu_data_pkg::word_t'(sltu_bit);
            alu_op_pkg::OP_AND:  result = src1 & src2;
            alu_op_pkg::OP_OR:   result = src1 | src2;
            alu_op_pkg::OP_NOR:  result = ~(src1 | src2);
            alu_op_pkg::OP_XOR:  result = src1 ^ src2;
            alu_op_pkg::OP_LUI:  result = {src2[HALF-1:0], {HALF{1'b0}}};
            alu_op_pkg::OP_SLL:  result = src2 << sa;
            alu_op_pkg::OP_SRL:  result = src2 >> sa;
            alu_op_pkg::OP_SRA:  result = $signed(src2) >>> sa;
            alu_op_pkg::OP_CLO,
            alu_op_pkg::OP_CLZ:  result = alu_data_pkg::word_t'(lead_cnt);
            alu_op_pkg::OP_MOVN: result = src1_zero ? '0 : src2;   // src1 is the test value
            alu_op_pkg::OP_MOVZ: result = src1_zero ? src2 : '0;
            alu_op_pkg::OP_MFHI: result = hi;
            alu_op_pkg::OP_MFLO: result = lo;
            default:             result = '0;
        endcase
    end

    always_comb begin
        case (op)
            alu_op_pkg::OP_TEQ:  tcond = alu_op_pkg::TRAP_EQ;
            alu_op_pkg::OP_TNE:  tcond = alu_op_pkg::TRAP_NE;
            alu_op_pkg::OP_TGE:  tcond = alu_op_pkg::TRAP_GE;
            alu_op_pkg::OP_TGEU: tcond = alu_op_pkg::TRAP_GEU;
            alu_op_pkg::OP_TLT:  tcond = alu_op_pkg::TRAP_LT;
            alu_op_pkg::OP_TLTU: tcond = alu_op_pkg::TRAP_LTU;
            default:             tcond = alu_op_pkg::TRAP_NONE;
        endcase
    end

    bit_count_lead u_lead (
        .value      (src1),
        .count_ones (op == alu_op_pkg::OP_CLO),
        .count      (lead_cnt)
    );

    trap_cond u_trap (
        .cond (tcond),
        .a    (src1),
        .b    (src2),
        .trap (trap)
    );

    hilo_unit u_hilo (
        .clk     (clk),
        .reset   (reset),
        .op      (op),
        .src1    (src1),
        .src2    (src2),
        .flush   (flush),
        .hi      (hi),
        .lo      (lo),
        .busy    (busy),
        .md_done (md_done),
        .md      (md_bus)
    );

    pipe_multiplier u_mul (
        .clk   (clk),
        .reset (reset),
        .md    (md_bus)
    );

    iter_divider u_div (
        .clk   (clk),
        .reset (reset),
        .md    (md_bus)
    );

endmodule

// ==== test/tb_alu.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_alu;

    localparam int N_SINGLE = 24;    // OP_ADD through OP_TLTU
    localparam int N_RAND   = 40;
    localparam int N_MUL    = 8;
    localparam int N_DIV    = 12;
    localparam int MAX_CYCLES = 20 + N_SINGLE * (N_RAND + 25) + 4 * (`DATA_W + 2)
                              + 6 * N_MUL * (`MUL_STAGES + 4) + 2 * N_DIV * (`DIV_ITERS + 5)
                              + 200;

    logic clk;
    logic reset;
    logic flush;
    logic overflow;
    logic trap;
    logic busy;
    logic md_done;
    alu_op_pkg::alu_op_e  op;
    alu_data_pkg::word_t  src1;
    alu_data_pkg::word_t  src2;
    alu_data_pkg::word_t  result;
    alu_data_pkg::word_t  exp_hi;
    alu_data_pkg::word_t  exp_lo;
    alu_data_pkg::word_t  exp_res;
    logic [31:0]          lfsr_state;
    int value_errs;
    int other_errs;
    int cycle_cnt;

    alu u_dut (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .flush    (flush),
        .result   (result),
        .overflow (overflow),
        .trap     (trap),
        .busy     (busy),
        .md_done  (md_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output alu_data_pkg::word_t w);
        for (int i = 0; i < `DATA_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[`DATA_W-2:0], lfsr_state[0]};
        end
    endtask

    function automatic alu_data_pkg::word_t lead_count(input alu_data_pkg::word_t v,
                                                       input logic ones);
        int c;
        logic stop;
        c = 0;
        stop = 1'b0;
        for (int i = `DATA_W - 1; i >= 0; i--) begin
            if (!stop && v[i] == ones) c++;
            else stop = 1'b1;
        end
        return alu_data_pkg::word_t'(c);
    endfunction

    function automatic alu_data_pkg::word_t result_of(input alu_op_pkg::alu_op_e o,
            input alu_data_pkg::word_t a, input alu_data_pkg::word_t b,
            input alu_data_pkg::word_t hi_v, input alu_data_pkg::word_t lo_v);
        case (o)
            alu_op_pkg::OP_ADD, alu_op_pkg::OP_ADDU: return a + b;
            alu_op_pkg::OP_SUB, alu_op_pkg::OP_SUBU: return a - b;
            alu_op_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            alu_op_pkg::OP_SLTU: return (a < b) ? 1 : 0;
            alu_op_pkg::OP_AND:  return a & b;
            alu_op_pkg::OP_OR:   return a | b;
            alu_op_pkg::OP_NOR:  return ~(a | b);
            alu_op_pkg::OP_XOR:  return a ^ b;
            alu_op_pkg::OP_LUI:  return b << 16;
            alu_op_pkg::OP_SLL:  return b << a[4:0];    // amount from src1
            alu_op_pkg::OP_SRL:  return b >> a[4:0];
            alu_op_pkg::OP_SRA:  return $signed(b) >>> a[4:0];
            alu_op_pkg::OP_CLO:  return lead_count(a, 1'b1);
            alu_op_pkg::OP_CLZ:  return lead_count(a, 1'b0);
            alu_op_pkg::OP_MOVN: return (a != 0) ? b : 0;
            alu_op_pkg::OP_MOVZ: return (a == 0) ? b : 0;
            alu_op_pkg::OP_MFHI: return hi_v;
            alu_op_pkg::OP_MFLO: return lo_v;
            default:             return 0;
        endcase
    endfunction

    function automatic logic overflows(input alu_op_pkg::alu_op_e o,
            input alu_data_pkg::word_t a, input alu_data_pkg::word_t b);
        longint s;
        if (o == alu_op_pkg::OP_ADD) s = longint'($signed(a)) + longint'($signed(b));
        else if (o == alu_op_pkg::OP_SUB) s = longint'($signed(a)) - longint'($signed(b));
        else return 1'b0;
        return (s > longint'(32'sh7fffffff)) || (s < longint'(32'sh80000000));
    endfunction

    function automatic logic trap_taken(input alu_op_pkg::alu_op_e o,
            input alu_data_pkg::word_t a, input alu_data_pkg::word_t b);
        case (o)
            alu_op_pkg::OP_TEQ:  return a == b;
            alu_op_pkg::OP_TNE:  return a != b;
            alu_op_pkg::OP_TGE:  return !($signed(a) < $signed(b));
            alu_op_pkg::OP_TGEU: return !(a < b);
            alu_op_pkg::OP_TLT:  return $signed(a) < $signed(b);
            alu_op_pkg::OP_TLTU: return a < b;
            default:             return 1'b0;
        endcase
    endfunction

    // new {hi, lo} after a multiply-type or divide op
    function automatic alu_data_pkg::dword_t hilo_after(input alu_op_pkg::alu_op_e o,
            input alu_data_pkg::word_t a, input alu_data_pkg::word_t b,
            input alu_data_pkg::dword_t hilo);
        alu_data_pkg::dword_t p;
        alu_data_pkg::word_t  am;
        alu_data_pkg::word_t  bm;
        alu_data_pkg::word_t  q;
        alu_data_pkg::word_t  rm;
        logic sgn;
        sgn = (o == alu_op_pkg::OP_MULT || o == alu_op_pkg::OP_MADD
               || o == alu_op_pkg::OP_MSUB || o == alu_op_pkg::OP_DIV);
        if (sgn) p = {{`DATA_W{a[`DATA_W-1]}}, a} * {{`DATA_W{b[`DATA_W-1]}}, b};
        else p = {{`DATA_W{1'b0}}, a} * {{`DATA_W{1'b0}}, b};
        am = (sgn && a[`DATA_W-1]) ? -a : a;
        bm = (sgn && b[`DATA_W-1]) ? -b : b;
        if (bm == 0) begin
            q  = '1;      // divide by zero
            rm = am;
        end else begin
            q  = am / bm;
            rm = am % bm;
        end
        if (sgn && (a[`DATA_W-1] ^ b[`DATA_W-1])) q = -q;
        if (sgn && a[`DATA_W-1]) rm = -rm;
        case (o)
            alu_op_pkg::OP_MADD, alu_op_pkg::OP_MADDU: return hilo + p;
            alu_op_pkg::OP_MSUB, alu_op_pkg::OP_MSUBU: return hilo - p;
            alu_op_pkg::OP_DIV, alu_op_pkg::OP_DIVU:   return {rm, q};
            default:                                   return p;
        endcase
    endfunction

    // combinational outputs checked mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            exp_res = result_of(op, src1, src2, exp_hi, exp_lo);
            assert (result === exp_res) else begin
                value_errs++;
                $display("MISMATCH result op=%0h src1=%h src2=%h got %h exp %h",
                         op, src1, src2, result, exp_res);
            end
            assert (overflow === overflows(op, src1, src2)) else begin
                value_errs++;
                $display("MISMATCH overflow op=%0h src1=%h src2=%h got %h exp %h",
                         op, src1, src2, overflow, overflows(op, src1, src2));
            end
            assert (trap === trap_taken(op, src1, src2)) else begin
                value_errs++;
                $display("MISMATCH trap op=%0h src1=%h src2=%h got %h exp %h",
                         op, src1, src2, trap, trap_taken(op, src1, src2));
            end
        end
    end

    // one op for one cycle, entered and left at edge plus 1 ns
    task automatic step(input alu_op_pkg::alu_op_e o, input alu_data_pkg::word_t a,
                        input alu_data_pkg::word_t b);
        op   = o;
        src1 = a;
        src2 = b;
        @(posedge clk);
        #1;
    endtask

    task automatic run_md(input alu_op_pkg::alu_op_e o, input alu_data_pkg::word_t a,
                          input alu_data_pkg::word_t b, input logic kill);
        int n;
        int lat;
        alu_data_pkg::dword_t nxt;
        lat = (o == alu_op_pkg::OP_DIV || o == alu_op_pkg::OP_DIVU) ? `DIV_ITERS + 2
                                                                    : `MUL_STAGES + 1;
        nxt  = hilo_after(o, a, b, {exp_hi, exp_lo});
        op   = o;
        src1 = a;
        src2 = b;
        n    = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            assert (busy === 1'b1) else begin
                value_errs++;
                $display("MISMATCH busy op=%0h cycle %0d got %h exp 1", o, n, busy);
            end
        end while (md_done !== 1'b1 && n < 2 * `DIV_ITERS + 8);
        assert (md_done === 1'b1) else begin
            other_errs++;
            $display("no completion pulse for op %0h a=%h b=%h", o, a, b);
        end
        assert (n == lat) else begin
            value_errs++;
            $display("MISMATCH md_done latency op=%0h got %h exp %h", o, n, lat);
        end
        flush = kill;    // drop the result on the done edge
        @(posedge clk);
        #1;
        if (!kill) {exp_hi, exp_lo} = nxt;
        assert (busy === 1'b0) else begin
            value_errs++;
            $display("MISMATCH busy after done op=%0h got %h exp 0", o, busy);
        end
        flush = 1'b0;
        step(alu_op_pkg::OP_MFHI, 0, 0);
        step(alu_op_pkg::OP_MFLO, 0, 0);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, tests did not complete (%0d value mismatches, %0d other failures)",
                 cycle_cnt, value_errs, other_errs);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        alu_data_pkg::word_t a;
        alu_data_pkg::word_t b;
        alu_data_pkg::word_t corners [5];
        alu_data_pkg::word_t div_a [8];
        alu_data_pkg::word_t div_b [8];
        corners = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};
        div_a = '{100, -100, 100, -100, 5, -5, 32'h80000000, 0};
        div_b = '{7, 7, -7, -7, 0, 0, 32'hffffffff, 3};
        lfsr_state = 32'h8a15_447a;
        value_errs = 0;
        other_errs = 0;
        exp_hi = '0;
        exp_lo = '0;
        reset = 1'b1;
        flush = 1'b0;
        op    = alu_op_pkg::OP_NOP;
        src1  = '0;
        src2  = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // corner pairs cover equal, signed-less and unsigned-less traps
        for (int i = 0; i < 5; i++)
            for (int j = 0; j < 5; j++)
                for (int k = 1; k <= N_SINGLE; k++)
                    step(alu_op_pkg::alu_op_e'(k), corners[i], corners[j]);
        for (int r = 0; r < N_RAND; r++) begin
            rand_word(a);
            rand_word(b);
            for (int k = 1; k <= N_SINGLE; k++) step(alu_op_pkg::alu_op_e'(k), a, b);
        end

        // clo/clz edge words
        step(alu_op_pkg::OP_CLO, '1, 0);
        step(alu_op_pkg::OP_CLZ, '1, 0);
        step(alu_op_pkg::OP_CLO, '0, 0);
        step(alu_op_pkg::OP_CLZ, '0, 0);
        for (int i = 0; i < `DATA_W; i++) begin
            step(alu_op_pkg::OP_CLZ, 1 << i, 0);
            step(alu_op_pkg::OP_CLO, ~(1 << i), 0);
        end

        for (int r = 0; r < N_MUL; r++) begin
            rand_word(a);
            rand_word(b);
            if (r == 0) begin
                a = 32'h80000000;
                b = 32'hffffffff;
            end
            for (int k = alu_op_pkg::OP_MULT; k <= alu_op_pkg::OP_MSUBU; k++)
                run_md(alu_op_pkg::alu_op_e'(k), a, b, 1'b0);
        end

        for (int r = 0; r < N_DIV; r++) begin
            if (r < 8) begin
                a = div_a[r];
                b = div_b[r];
            end else begin
                rand_word(a);
                rand_word(b);
            end
            run_md(alu_op_pkg::OP_DIV, a, b, 1'b0);
            run_md(alu_op_pkg::OP_DIVU, a, b, 1'b0);
        end

        step(alu_op_pkg::OP_MTHI, 32'h1234_5678, 0);
        exp_hi = 32'h1234_5678;
        step(alu_op_pkg::OP_MTLO, 32'h9abc_def0, 0);
        exp_lo = 32'h9abc_def0;
        step(alu_op_pkg::OP_MFHI, 0, 0);
        step(alu_op_pkg::OP_MFLO, 0, 0);
        run_md(alu_op_pkg::OP_MULT, 32'h0000_0003, 32'hffff_fff9, 1'b1);   // flushed
        run_md(alu_op_pkg::OP_MADDU, 32'h0001_0000, 32'h0001_0000, 1'b0);

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/alu_op_pkg.sv
rtl/alu_data_pkg.sv
rtl/muldiv_if.sv
rtl/bit_count_lead.sv
rtl/trap_cond.sv
rtl/pipe_multiplier.sv
rtl/iter_divider.sv
rtl/hilo_unit.sv
rtl/alu.sv
test/tb_alu.sv

// ==== Bender.yml ====
package:
  name: mips_alu

export_include_dirs:
  - rtl

sources:
  - rtl/alu_op_pkg.sv
  - rtl/alu_data_pkg.sv
  - rtl/muldiv_if.sv
  - rtl/bit_count_lead.sv
  - rtl/trap_cond.sv
  - rtl/pipe_multiplier.sv
  - rtl/iter_divider.sv
  - rtl/hilo_unit.sv
  - rtl/alu.sv
  - target: test
    files:
      - test/tb_alu.sv
